// File: bench/ooo_dispatch_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module ooo_dispatch_tb;

    localparam int N_INSTR        = 600;
    localparam int TIMEOUT_CYCLES = N_INSTR * 6 + 200;

    logic                   clk;
    logic                   reset;
    ooo_pkg::decoded_pack_t decoded;
    logic                   decoded_valid;
    logic                   stall;
    logic [`OOO_RS_NUM-1:0] rs_full;
    logic [`OOO_RS_NUM-1:0] rs_load;
    ooo_pkg::rs_entry_t     rs_entry;
    ooo_pkg::cdb_t          cdb;
    ooo_pkg::commit_t       commit;

    // reference model state
    logic [`OOO_XLEN-1:0]         m_regs     [`OOO_REG_NUM];
    logic                         m_map_busy [`OOO_REG_NUM];
    ooo_pkg::rob_tag_t            m_map_tag  [`OOO_REG_NUM];
    logic                         m_busy     [`OOO_ROB_SIZE];
    logic                         m_done     [`OOO_ROB_SIZE];
    logic [`OOO_XLEN-1:0]         m_val      [`OOO_ROB_SIZE];
    logic [`OOO_REG_ADDR_LEN-1:0] m_rd       [`OOO_ROB_SIZE];
    logic                         m_wr       [`OOO_ROB_SIZE];
    ooo_pkg::rob_tag_t            m_head;
    ooo_pkg::rob_tag_t            m_tail;
    int                           m_count;

    logic [`OOO_RS_NUM-1:0] exp_load; // predicted for the cycle after acceptance
    ooo_pkg::rs_entry_t     exp_entry;
    logic                   took;
    int                     n_issued;
    int                     n_accepted;
    int                     cycles;

    ooo_dispatch_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .decoded_valid (decoded_valid),
        .stall         (stall),
        .rs_full       (rs_full),
        .rs_load       (rs_load),
        .rs_entry      (rs_entry),
        .cdb           (cdb),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        $display("Result: FAILED");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic check_rs_entry(input ooo_pkg::rs_entry_t got, input ooo_pkg::rs_entry_t exp);
        if (got.pc !== exp.pc) report_mismatch("rs_entry.pc", got.pc, exp.pc);
        if (got.fu !== exp.fu) report_mismatch("rs_entry.fu", got.fu, exp.fu);
        if (got.func !== exp.func) report_mismatch("rs_entry.func", got.func, exp.func);
        if (got.imm !== exp.imm) report_mismatch("rs_entry.imm", got.imm, exp.imm);
        if (got.dest_tag !== exp.dest_tag)
            report_mismatch("rs_entry.dest_tag", got.dest_tag, exp.dest_tag);
        if (got.src1 !== exp.src1) report_mismatch("rs_entry.src1", got.src1, exp.src1);
        if (got.src2 !== exp.src2) report_mismatch("rs_entry.src2", got.src2, exp.src2);
    endtask

    task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
        if (got.valid !== exp.valid) report_mismatch("commit.valid", got.valid, exp.valid);
        if (exp.valid) begin // other fields only mean something while valid
            if (got.tag !== exp.tag) report_mismatch("commit.tag", got.tag, exp.tag);
            if (got.rd !== exp.rd) report_mismatch("commit.rd", got.rd, exp.rd);
            if (got.writes_rd !== exp.writes_rd)
                report_mismatch("commit.writes_rd", got.writes_rd, exp.writes_rd);
            if (got.value !== exp.value) report_mismatch("commit.value", got.value, exp.value);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) report_mismatch("stall", got, exp);
    endtask

    task automatic check_load(input logic [`OOO_RS_NUM-1:0] got,
                              input logic [`OOO_RS_NUM-1:0] exp);
        if (got !== exp) report_mismatch("rs_load", got, exp);
    endtask

    // small registers most of the time, so producers and consumers collide
    function automatic logic [`OOO_REG_ADDR_LEN-1:0] pick_reg();
        logic [`OOO_REG_ADDR_LEN-1:0] r;
        if ($urandom_range(0, 9) < 8) begin
            r = `OOO_REG_ADDR_LEN'($urandom_range(0, 7));
        end else begin
            r = `OOO_REG_ADDR_LEN'($urandom_range(0, `OOO_REG_NUM - 1));
        end
        return r;
    endfunction

    function automatic ooo_pkg::decoded_pack_t random_instr(input int idx);
        ooo_pkg::decoded_pack_t d;
        d.pc        = `OOO_XLEN'(32'h1000 + idx * 4);
        d.fu        = ooo_pkg::fu_class_e'($urandom_range(0, 3));
        d.func      = 4'($urandom_range(0, 15));
        d.imm       = `OOO_XLEN'($urandom());
        d.rd        = pick_reg();
        d.rs1       = pick_reg();
        d.rs2       = pick_reg();
        d.writes_rd = ($urandom_range(0, 3) != 0);
        return d;
    endfunction

    // source operand as the model sees it before this instruction renames
    function automatic ooo_pkg::operand_t model_operand(input logic [`OOO_REG_ADDR_LEN-1:0] src);
        ooo_pkg::operand_t op;
        ooo_pkg::rob_tag_t t;
        op = '0;
        t  = m_map_tag[src];
        if (src == '0 || !m_map_busy[src]) begin
            op.ready      = 1'b1;
            op.data.value = m_regs[src];
        end else if (m_done[t]) begin
            op.ready      = 1'b1;
            op.data.value = m_val[t];
        end else if (cdb.valid && cdb.tag == t) begin
            op.ready      = 1'b1;
            op.data.value = cdb.value;
        end else begin
            op.data.value = `OOO_XLEN'(t); // tag in the low bits with zero above
        end
        return op;
    endfunction

    task automatic drive_inputs();
        ooo_pkg::rob_tag_t open_tags[$];
        if (!decoded_valid || took) begin // a stalled instruction stays put
            if (n_issued < N_INSTR && $urandom_range(0, 99) < 85) begin
                decoded       = random_instr(n_issued);
                decoded_valid = 1'b1;
                n_issued++;
            end else begin
                decoded_valid = 1'b0;
            end
        end
        for (int i = 0; i < `OOO_RS_NUM; i++) begin
            rs_full[i] = ($urandom_range(0, 3) == 0);
        end
        for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
            if (m_busy[i] && !m_done[i]) open_tags.push_back(ooo_pkg::rob_tag_t'(i));
        end
        cdb = '0;
        if (open_tags.size() > 0 && $urandom_range(0, 3) != 0) begin
            cdb.valid = 1'b1;
            cdb.tag   = open_tags[$urandom_range(0, open_tags.size() - 1)];
            cdb.value = `OOO_XLEN'($urandom());
        end
    endtask

    // checks outputs between edges and then applies the coming edge to the model
    task automatic check_and_advance();
        ooo_pkg::commit_t exp_commit;
        logic             exp_stall;
        logic             take;
        exp_commit = '0;
        if (m_busy[m_head] && m_done[m_head]) begin
            exp_commit = '{valid: 1'b1, tag: m_head, rd: m_rd[m_head],
                           writes_rd: m_wr[m_head], value: m_val[m_head]};
        end
        check_commit(commit, exp_commit);
        exp_stall = decoded_valid && (rs_full[decoded.fu] || m_count == `OOO_ROB_SIZE);
        check_stall(stall, exp_stall);
        check_load(rs_load, exp_load);
        if (exp_load != '0) check_rs_entry(rs_entry, exp_entry);

        take     = decoded_valid && !exp_stall;
        exp_load = '0;
        if (take) begin
            exp_entry.pc          = decoded.pc;
            exp_entry.fu          = decoded.fu;
            exp_entry.func        = decoded.func;
            exp_entry.imm         = decoded.imm;
            exp_entry.dest_tag    = m_tail;
            exp_entry.src1        = model_operand(decoded.rs1);
            exp_entry.src2        = model_operand(decoded.rs2);
            exp_load[decoded.fu]  = 1'b1;
        end

        if (exp_commit.valid) begin
            if (exp_commit.writes_rd && exp_commit.rd != '0) begin
                m_regs[exp_commit.rd] = exp_commit.value;
            end
            if (exp_commit.writes_rd && m_map_tag[exp_commit.rd] == m_head) begin
                m_map_busy[exp_commit.rd] = 1'b0; // only if still the newest producer
            end
            m_busy[m_head] = 1'b0;
            m_done[m_head] = 1'b0;
            m_head++;
            m_count--;
        end
        if (cdb.valid) begin
            m_done[cdb.tag] = 1'b1;
            m_val[cdb.tag]  = cdb.value;
        end
        if (take) begin
            m_busy[m_tail] = 1'b1;
            m_done[m_tail] = 1'b0;
            m_rd[m_tail]   = decoded.rd;
            m_wr[m_tail]   = decoded.writes_rd;
            if (decoded.writes_rd && decoded.rd != '0) begin // rename beats the clear
                m_map_busy[decoded.rd] = 1'b1;
                m_map_tag[decoded.rd]  = m_tail;
            end
            m_tail++;
            m_count++;
            n_accepted++;
        end
        took = take;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("dispatch did not finish in time, %0d cycles elapsed", cycles);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(27));
        reset         = 1'b1;
        decoded       = '0;
        decoded_valid = 1'b0;
        rs_full       = '0;
        cdb           = '0;
        for (int i = 0; i < `OOO_REG_NUM; i++) begin
            m_regs[i]     = '0;
            m_map_busy[i] = 1'b0;
            m_map_tag[i]  = '0;
        end
        for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
            m_busy[i] = 1'b0;
            m_done[i] = 1'b0;
            m_val[i]  = '0;
            m_rd[i]   = '0;
            m_wr[i]   = 1'b0;
        end
        m_head      = '0;
        m_tail      = '0;
        m_count     = 0;
        exp_load    = '0;
        exp_entry   = '0;
        took        = 1'b0;
        n_issued    = 0;
        n_accepted  = 0;

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        drive_inputs();
        while (n_accepted < N_INSTR || m_count != 0 || exp_load != '0) begin
            @(negedge clk); // outputs settled and inputs held since the edge
            check_and_advance();
            @(posedge clk);
            #2;
            drive_inputs();
        end

        // every accepted instruction has retired by now
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/arch_regfile.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module arch_regfile (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`OOO_REG_ADDR_LEN-1:0] read_addr1,
    input  logic [`OOO_REG_ADDR_LEN-1:0] read_addr2,
    output logic [`OOO_XLEN-1:0]         read_data1,
    output logic [`OOO_XLEN-1:0]         read_data2,
    input  ooo_pkg::commit_t             commit
);

    logic [`OOO_XLEN-1:0] regs [`OOO_REG_NUM];

    // x0 forced to zero on read as well as never written
    assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.writes_rd && commit.rd != '0) begin
            regs[commit.rd] <= commit.value; // in-order retirement write
        end
    end

endmodule

`default_nettype wire

// File: design/dispatcher.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module dispatcher (
    input  logic                         clk,
    input  logic                         reset,
    input  ooo_pkg::decoded_pack_t       decoded,
    input  logic                         decoded_valid,
    input  logic [`OOO_RS_NUM-1:0]       rs_full,
    output logic                         stall,
    output logic [`OOO_RS_NUM-1:0]       rs_load,
    output ooo_pkg::rs_entry_t           rs_entry,
    output logic [`OOO_REG_ADDR_LEN-1:0] reg_addr1,
    output logic [`OOO_REG_ADDR_LEN-1:0] reg_addr2,
    input  logic [`OOO_XLEN-1:0]         reg_data1,
    input  logic [`OOO_XLEN-1:0]         reg_data2,
    output ooo_pkg::rob_alloc_t          rob_alloc,
    input  ooo_pkg::rob_tag_t            alloc_tag,
    input  logic                         rob_full,
    output ooo_pkg::rob_tag_t            query_tag1,
    output ooo_pkg::rob_tag_t            query_tag2,
    input  ooo_pkg::rob_read_t           query1,
    input  ooo_pkg::rob_read_t           query2,
    input  ooo_pkg::cdb_t                cdb,
    input  ooo_pkg::commit_t             commit
);

    logic                    accept;
    logic                    rename_valid;
    ooo_pkg::map_entry_t     lookup1;
    ooo_pkg::map_entry_t     lookup2;
    ooo_pkg::rs_entry_t      next_entry;
    logic [`OOO_RS_NUM-1:0]  next_load;

    // regfile, then finished rob entry, then cdb bypass, else wait on tag
    function automatic ooo_pkg::operand_t build_operand(
        input logic [`OOO_REG_ADDR_LEN-1:0] src,
        input ooo_pkg::map_entry_t          ent,
        input ooo_pkg::rob_read_t           rob,
        input logic [`OOO_XLEN-1:0]         reg_val,
        input ooo_pkg::cdb_t                bus
    );
        ooo_pkg::operand_t op;
        op = '0;
        if (src == '0 || !ent.busy) begin
            op.ready      = 1'b1;
            op.data.value = reg_val;
        end else if (rob.done) begin
            op.ready      = 1'b1;
            op.data.value = rob.value;
        end else if (bus.valid && bus.tag == ent.tag) begin
            op.ready      = 1'b1;
            op.data.value = bus.value;
        end else begin
            op.data.pending.tag = ent.tag; // pad left at zero
        end
        return op;
    endfunction

    assign stall        = decoded_valid && (rs_full[decoded.fu] || rob_full);
    assign accept       = decoded_valid && !stall;
    assign rename_valid = accept && decoded.writes_rd && (decoded.rd != '0);

    assign reg_addr1  = decoded.rs1;
    assign reg_addr2  = decoded.rs2;
    assign query_tag1 = lookup1.tag;
    assign query_tag2 = lookup2.tag;

    assign rob_alloc = '{valid: accept, rd: decoded.rd, writes_rd: decoded.writes_rd};

    // lookups see the table before this instruction's own rename
    map_table map0 (
        .clk          (clk),
        .reset        (reset),
        .lookup_addr1 (decoded.rs1),
        .lookup_addr2 (decoded.rs2),
        .lookup1      (lookup1),
        .lookup2      (lookup2),
        .rename_valid (rename_valid),
        .rename_addr  (decoded.rd),
        .rename_tag   (alloc_tag),
        .commit       (commit)
    );

    always_comb begin
        next_entry.pc       = decoded.pc;
        next_entry.fu       = decoded.fu;
        next_entry.func     = decoded.func;
        next_entry.imm      = decoded.imm;
        next_entry.dest_tag = alloc_tag;
        next_entry.src1     = build_operand(decoded.rs1, lookup1, query1, reg_data1, cdb);
        next_entry.src2     = build_operand(decoded.rs2, lookup2, query2, reg_data2, cdb);
        next_load           = '0;
        if (accept) begin
            next_load[decoded.fu] = 1'b1; // station picked by fu class
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rs_load  <= '0;
            rs_entry <= '0;
        end else begin
            rs_load <= next_load;
            if (accept) begin
                rs_entry <= next_entry;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/map_table.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module map_table (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`OOO_REG_ADDR_LEN-1:0] lookup_addr1,
    input  logic [`OOO_REG_ADDR_LEN-1:0] lookup_addr2,
    output ooo_pkg::map_entry_t          lookup1,
    output ooo_pkg::map_entry_t          lookup2,
    input  logic                         rename_valid,
    input  logic [`OOO_REG_ADDR_LEN-1:0] rename_addr,
    input  ooo_pkg::rob_tag_t            rename_tag,
    input  ooo_pkg::commit_t             commit
);

    ooo_pkg::map_entry_t map [`OOO_REG_NUM];
    logic                clear_hit;

    // only clear when the retiring entry is still the newest producer
    assign clear_hit = commit.valid && commit.writes_rd
                       && map[commit.rd].busy && (map[commit.rd].tag == commit.tag);

    assign lookup1 = map[lookup_addr1];
    assign lookup2 = map[lookup_addr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_REG_NUM; i++) begin
                map[i] <= '0;
            end
        end else begin
            if (clear_hit) begin
                map[commit.rd].busy <= 1'b0;
            end
            // later assignment, so a same-cycle rename beats the clear
            if (rename_valid) begin
                map[rename_addr].busy <= 1'b1;
                map[rename_addr].tag  <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ooo_dispatch_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module ooo_dispatch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  ooo_pkg::decoded_pack_t decoded,
    input  logic                   decoded_valid,
    output logic                   stall,
    input  logic [`OOO_RS_NUM-1:0] rs_full,
    output logic [`OOO_RS_NUM-1:0] rs_load,
    output ooo_pkg::rs_entry_t     rs_entry,
    input  ooo_pkg::cdb_t          cdb,
    output ooo_pkg::commit_t       commit
);

    ooo_pkg::rob_alloc_t          rob_alloc;
    ooo_pkg::rob_tag_t            alloc_tag;
    logic                         rob_full;
    ooo_pkg::rob_tag_t            query_tag1;
    ooo_pkg::rob_tag_t            query_tag2;
    ooo_pkg::rob_read_t           query1;
    ooo_pkg::rob_read_t           query2;
    logic [`OOO_REG_ADDR_LEN-1:0] reg_addr1;
    logic [`OOO_REG_ADDR_LEN-1:0] reg_addr2;
    logic [`OOO_XLEN-1:0]         reg_data1;
    logic [`OOO_XLEN-1:0]         reg_data2;

    dispatcher disp0 (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .decoded_valid (decoded_valid),
        .rs_full       (rs_full),
        .stall         (stall),
        .rs_load       (rs_load),
        .rs_entry      (rs_entry),
        .reg_addr1     (reg_addr1),
        .reg_addr2     (reg_addr2),
        .reg_data1     (reg_data1),
        .reg_data2     (reg_data2),
        .rob_alloc     (rob_alloc),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .query_tag1    (query_tag1),
        .query_tag2    (query_tag2),
        .query1        (query1),
        .query2        (query2),
        .cdb           (cdb),
        .commit        (commit)
    );

    reorder_buffer rob0 (
        .clk        (clk),
        .reset      (reset),
        .alloc      (rob_alloc),
        .alloc_tag  (alloc_tag),
        .full       (rob_full),
        .query_tag1 (query_tag1),
        .query_tag2 (query_tag2),
        .query1     (query1),
        .query2     (query2),
        .cdb        (cdb),
        .commit     (commit)
    );

    // commit feeds the regfile here and the map table inside the dispatcher
    arch_regfile regs0 (
        .clk        (clk),
        .reset      (reset),
        .read_addr1 (reg_addr1),
        .read_addr2 (reg_addr2),
        .read_data1 (reg_data1),
        .read_data2 (reg_data2),
        .commit     (commit)
    );

endmodule

`default_nettype wire

// File: design/ooo_pkg.sv
`default_nettype none

`include "ooo_config.svh"

package ooo_pkg;

    // index also picks the reservation station
    typedef enum logic [1:0] {FU_ALU, FU_MUL, FU_BRANCH, FU_MEM} fu_class_e;

    typedef logic [`OOO_ROB_TAG_LEN-1:0] rob_tag_t;

    typedef struct packed {
        logic [`OOO_XLEN-1:0]         pc;
        fu_class_e                    fu;
        logic [3:0]                   func;
        logic [`OOO_XLEN-1:0]         imm;
        logic [`OOO_REG_ADDR_LEN-1:0] rd;
        logic [`OOO_REG_ADDR_LEN-1:0] rs1;
        logic [`OOO_REG_ADDR_LEN-1:0] rs2;
        logic                         writes_rd;
    } decoded_pack_t;

    // value when ready, producer tag while waiting
    typedef union packed {
        logic [`OOO_XLEN-1:0] value;
        struct packed {
            logic [`OOO_XLEN-`OOO_ROB_TAG_LEN-1:0] pad; // kept zero
            rob_tag_t                              tag;
        } pending;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u data;
    } operand_t;

    typedef struct packed {
        logic [`OOO_XLEN-1:0] pc;
        fu_class_e            fu;
        logic [3:0]           func;
        logic [`OOO_XLEN-1:0] imm;
        rob_tag_t             dest_tag;
        operand_t             src1;
        operand_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic                 valid;
        rob_tag_t             tag;
        logic [`OOO_XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic                         valid;
        rob_tag_t                     tag;
        logic [`OOO_REG_ADDR_LEN-1:0] rd;
        logic                         writes_rd;
        logic [`OOO_XLEN-1:0]         value;
    } commit_t;

    typedef struct packed {
        logic                         valid;
        logic [`OOO_REG_ADDR_LEN-1:0] rd;
        logic                         writes_rd;
    } rob_alloc_t;

    typedef struct packed {
        logic                 done;
        logic [`OOO_XLEN-1:0] value;
    } rob_read_t;

    typedef struct packed {
        logic     busy; // a rob entry still owns the register
        rob_tag_t tag;
    } map_entry_t;

endpackage

`default_nettype wire

// File: design/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "ooo_config.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                reset,
    input  ooo_pkg::rob_alloc_t alloc,
    output ooo_pkg::rob_tag_t   alloc_tag,
    output logic                full,
    input  ooo_pkg::rob_tag_t   query_tag1,
    input  ooo_pkg::rob_tag_t   query_tag2,
    output ooo_pkg::rob_read_t  query1,
    output ooo_pkg::rob_read_t  query2,
    input  ooo_pkg::cdb_t       cdb,
    output ooo_pkg::commit_t    commit
);

    typedef struct packed {
        logic                         busy;
        logic                         done; // result captured from cdb
        logic [`OOO_REG_ADDR_LEN-1:0] rd;
        logic                         writes_rd;
        logic [`OOO_XLEN-1:0]         value;
    } rob_entry_t;

    rob_entry_t                 entries [`OOO_ROB_SIZE];
    ooo_pkg::rob_tag_t          head;
    ooo_pkg::rob_tag_t          tail;
    logic [`OOO_ROB_TAG_LEN:0]  count; // one extra bit to tell full from empty
    logic                       retire;

    assign alloc_tag = tail;
    assign full      = (count == `OOO_ROB_SIZE);
    assign retire    = entries[head].busy && entries[head].done;

    // done is cleared on retire, so it implies busy
    assign query1.done  = entries[query_tag1].done;
    assign query1.value = entries[query_tag1].value;
    assign query2.done  = entries[query_tag2].done;
    assign query2.value = entries[query_tag2].value;

    always_comb begin
        commit.valid     = retire;
        commit.tag       = head;
        commit.rd        = entries[head].rd;
        commit.writes_rd = entries[head].writes_rd;
        commit.value     = entries[head].value;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
                entries[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // dispatcher stalls on full, so tail never lands on a live entry
            if (alloc.valid) begin
                entries[tail] <= '{busy:      1'b1,
                                   done:      1'b0,
                                   rd:        alloc.rd,
                                   writes_rd: alloc.writes_rd,
                                   value:     '0};
                tail <= tail + 1'b1; // wraps, depth is a power of two
            end
            if (cdb.valid) begin
                entries[cdb.tag].done  <= 1'b1;
                entries[cdb.tag].value <= cdb.value;
            end
            if (retire) begin
                entries[head].busy <= 1'b0;
                entries[head].done <= 1'b0;
                head               <= head + 1'b1;
            end
            count <= count + alloc.valid - retire;
        end
    end

endmodule

`default_nettype wire

// File: include/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// datapath width
`define OOO_XLEN 32

// architectural register file
`define OOO_REG_NUM 32
`define OOO_REG_ADDR_LEN 5

// reorder buffer, tag width is log2 of depth
`define OOO_ROB_SIZE 8
`define OOO_ROB_TAG_LEN 3

// one station per fu class
`define OOO_RS_NUM 4

`endif

// File: ooo_dispatch.f
+incdir+include
design/ooo_pkg.sv
design/map_table.sv
design/dispatcher.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/ooo_dispatch_top.sv
bench/ooo_dispatch_tb.sv
